/* hw/decode_config.svh */
/*
 * Decode stage sizing
 * Word width, register file size and the link register number
 */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Word and register width
`define DATA_WIDTH 32

// Architectural registers
`define REG_COUNT 32
`define REG_IDX_W 5

`define LINK_REG 31  // Written by JAL

`endif

/* hw/decodePkg.sv */
/*
 * Decode stage types
 * Opcode and function codes, instruction word views, control word
 */
`include "decode_config.svh"

package decodePkg;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FUNCT_JR   = 6'h08;  // SPECIAL function field

    typedef enum logic [1:0] {
        kindR       = 2'd0,
        kindI       = 2'd1,
        kindJ       = 2'd2,
        kindInvalid = 2'd3
    } insnKind_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } rView_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [15:0]           imm;
    } iView_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jView_t;

    // Same 32 bits, field layout picked by opcode
    typedef union packed {
        rView_t r;
        iView_t i;
        jView_t j;
    } insnWord_u;

    typedef struct packed {
        insnKind_e kind;
        logic      regWe;
        logic      memRead;
        logic      memWe;
        logic      link;
    } ctrl_t;

endpackage

/* hw/hazardIf.sv */
/*
 * Pending register writes
 * Destinations still in flight in the ALU and memory stages
 */
`timescale 1ns/1ps
`include "decode_config.svh"

interface hazardIf;

    logic                  aluWe;
    logic [`REG_IDX_W-1:0] aluRd;  // Execute stage destination
    logic                  memWe;
    logic [`REG_IDX_W-1:0] memRd;  // Memory stage destination

    // Top level fills it from its ports
    modport producer (output aluWe, aluRd, memWe, memRd);

    // Interlock logic
    modport check (input aluWe, aluRd, memWe, memRd);

    modport monitor (input aluWe, aluRd, memWe, memRd);

endinterface

/* hw/regFile.sv */
/*
 * Integer register file
 * Two combinational read ports and one write port with write-through,
 * register 0 hardwired to zero
 */
`timescale 1ns/1ps
`include "decode_config.svh"

module regFile (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [`REG_IDX_W-1:0]  rsIdx,
    input  logic [`REG_IDX_W-1:0]  rtIdx,
    output logic [`DATA_WIDTH-1:0] rsData,
    output logic [`DATA_WIDTH-1:0] rtData,
    input  logic                   wbWe,
    input  logic [`REG_IDX_W-1:0]  wbRd,
    input  logic [`DATA_WIDTH-1:0] wbData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   wbValid;

    assign wbValid = wbWe && (wbRd != '0);  // Drop writes to r0

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbRd] <= wbData;
        end
    end

    // Same cycle writeback bypasses the array
    assign rsData = (wbValid && (wbRd == rsIdx)) ? wbData : regs[rsIdx];
    assign rtData = (wbValid && (wbRd == rtIdx)) ? wbData : regs[rtIdx];

endmodule

/* hw/insnDecoder.sv */
/*
 * Instruction decoder
 * Control word, destination register, source use and extended immediate
 */
`timescale 1ns/1ps
`include "decode_config.svh"

module insnDecoder (
    input  decodePkg::insnWord_u   insn,
    output decodePkg::ctrl_t       ctrl,
    output logic [`REG_IDX_W-1:0]  dest,
    output logic                   useRs,
    output logic                   useRt,
    output logic [`DATA_WIDTH-1:0] imm
);

    import decodePkg::*;

    logic [`REG_IDX_W-1:0]  destRaw;
    logic                   hasDest;
    logic                   isJr;
    logic [`DATA_WIDTH-1:0] immSext;
    logic [`DATA_WIDTH-1:0] immZext;
    logic [`DATA_WIDTH-1:0] targetZext;

    assign isJr       = (insn.r.funct == FUNCT_JR);
    assign immSext    = {{(`DATA_WIDTH-16){insn.i.imm[15]}}, insn.i.imm};
    assign immZext    = {{(`DATA_WIDTH-16){1'b0}}, insn.i.imm};
    assign targetZext = {{(`DATA_WIDTH-26){1'b0}}, insn.j.target};

    always_comb begin
        ctrl      = '0;
        ctrl.kind = kindInvalid;  // Unknown opcodes stay here
        destRaw   = '0;
        hasDest   = 1'b0;
        useRs     = 1'b0;
        useRt     = 1'b0;
        imm       = '0;

        case (insn.r.opcode)
            OP_SPECIAL: begin
                ctrl.kind = kindR;
                useRs     = 1'b1;
                useRt     = !isJr;
                hasDest   = !isJr;  // JR only reads rs
                destRaw   = insn.r.rd;
            end
            OP_ADDIU, OP_SLTI: begin
                ctrl.kind = kindI;
                useRs     = 1'b1;
                hasDest   = 1'b1;
                destRaw   = insn.i.rt;
                imm       = immSext;
            end
            OP_ORI: begin
                ctrl.kind = kindI;
                useRs     = 1'b1;
                hasDest   = 1'b1;
                destRaw   = insn.i.rt;
                imm       = immZext;
            end
            OP_LUI: begin
                ctrl.kind = kindI;
                hasDest   = 1'b1;
                destRaw   = insn.i.rt;
                imm       = immZext << 16;
            end
            OP_LW: begin
                ctrl.kind    = kindI;
                ctrl.memRead = 1'b1;
                useRs        = 1'b1;
                hasDest      = 1'b1;
                destRaw      = insn.i.rt;
                imm          = immSext;
            end
            OP_SW: begin
                ctrl.kind  = kindI;
                ctrl.memWe = 1'b1;
                useRs      = 1'b1;
                useRt      = 1'b1;  // Store data
                imm        = immSext;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.kind = kindI;
                useRs     = 1'b1;
                useRt     = 1'b1;
                imm       = immSext;
            end
            OP_BLEZ, OP_BGTZ, OP_REGIMM: begin
                ctrl.kind = kindI;  // Compare against zero
                useRs     = 1'b1;
                imm       = immSext;
            end
            OP_J: begin
                ctrl.kind = kindJ;
                imm       = targetZext;
            end
            OP_JAL: begin
                ctrl.kind = kindJ;
                ctrl.link = 1'b1;
                hasDest   = 1'b1;
                destRaw   = `REG_IDX_W'(`LINK_REG);
                imm       = targetZext;
            end
            default: begin
            end
        endcase

        // No write to r0, and no destination shown without a write
        ctrl.regWe = hasDest && (destRaw != '0);
        dest       = ctrl.regWe ? destRaw : '0;
    end

endmodule

/* hw/hazardUnit.sv */
/*
 * Read-after-write interlock
 * Stalls when a used source is still pending in the ALU or memory stage
 */
`timescale 1ns/1ps
`include "decode_config.svh"

module hazardUnit (
    hazardIf.check                hz,
    input  logic [`REG_IDX_W-1:0] rsIdx,
    input  logic [`REG_IDX_W-1:0] rtIdx,
    input  logic                  useRs,
    input  logic                  useRt,
    output logic                  stall
);

    logic rsAluHit;
    logic rsMemHit;
    logic rtAluHit;
    logic rtMemHit;
    logic rsHazard;
    logic rtHazard;

    // One stage's pending write against one source
    function automatic logic pendingMatch(
        input logic [`REG_IDX_W-1:0] idx,
        input logic                  stageWe,
        input logic [`REG_IDX_W-1:0] stageRd
    );
        return stageWe && (stageRd == idx);
    endfunction

    assign rsAluHit = pendingMatch(rsIdx, hz.aluWe, hz.aluRd);
    assign rsMemHit = pendingMatch(rsIdx, hz.memWe, hz.memRd);
    assign rtAluHit = pendingMatch(rtIdx, hz.aluWe, hz.aluRd);
    assign rtMemHit = pendingMatch(rtIdx, hz.memWe, hz.memRd);

    // r0 never carries a real dependency
    assign rsHazard = useRs && (rsIdx != '0) && (rsAluHit || rsMemHit);
    assign rtHazard = useRt && (rtIdx != '0) && (rtAluHit || rtMemHit);

    // Writeback is not checked, the register file forwards it
    assign stall = rsHazard || rtHazard;

endmodule

/* hw/decodeStage.sv */
/*
 * Pipeline decode stage
 * Valid/ready input from fetch, register read with interlock,
 * registered valid/ready output toward execute
 */
`timescale 1ns/1ps
`include "decode_config.svh"

module decodeStage (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   insnValid,
    output logic                   insnReady,
    input  logic [`DATA_WIDTH-1:0] insnWord,
    input  logic [`DATA_WIDTH-1:0] insnPc,
    input  logic                   wbWe,
    input  logic [`REG_IDX_W-1:0]  wbRd,
    input  logic [`DATA_WIDTH-1:0] wbData,
    input  logic                   aluWe,
    input  logic [`REG_IDX_W-1:0]  aluRd,
    input  logic                   memWe,
    input  logic [`REG_IDX_W-1:0]  memRd,
    input  logic                   outReady,
    output logic                   outValid,
    output logic [`DATA_WIDTH-1:0] outPc,
    output logic [`DATA_WIDTH-1:0] outInsn,
    output logic [`DATA_WIDTH-1:0] outRsData,
    output logic [`DATA_WIDTH-1:0] outRtData,
    output logic [`DATA_WIDTH-1:0] outImm,
    output logic [`REG_IDX_W-1:0]  outDest,
    output decodePkg::insnKind_e   outKind,
    output logic                   outRegWe,
    output logic                   outMemRead,
    output logic                   outMemWe,
    output logic                   outLink
);

    import decodePkg::*;

    insnWord_u              insn;
    ctrl_t                  decCtrl;
    logic [`REG_IDX_W-1:0]  decDest;
    logic [`DATA_WIDTH-1:0] decImm;
    logic                   useRs;
    logic                   useRt;
    logic [`DATA_WIDTH-1:0] rsData;
    logic [`DATA_WIDTH-1:0] rtData;
    logic                   stall;
    logic                   accept;
    ctrl_t                  outCtrl;

    hazardIf hz ();

    assign hz.aluWe = aluWe;
    assign hz.aluRd = aluRd;
    assign hz.memWe = memWe;
    assign hz.memRd = memRd;

    assign insn = insnWord;

    regFile uRegFile (
        .clock  (clock),
        .rstN   (rstN),
        .rsIdx  (insn.r.rs),
        .rtIdx  (insn.r.rt),
        .rsData (rsData),
        .rtData (rtData),
        .wbWe   (wbWe),
        .wbRd   (wbRd),
        .wbData (wbData)
    );

    insnDecoder uDecoder (
        .insn  (insn),
        .ctrl  (decCtrl),
        .dest  (decDest),
        .useRs (useRs),
        .useRt (useRt),
        .imm   (decImm)
    );

    hazardUnit uHazard (
        .hz    (hz),
        .rsIdx (insn.r.rs),
        .rtIdx (insn.r.rt),
        .useRs (useRs),
        .useRt (useRt),
        .stall (stall)
    );

    // Slot is free if empty or drained this cycle
    assign insnReady = (!outValid || outReady) && !(insnValid && stall);
    assign accept    = insnValid && insnReady;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;  // Drained, nothing new
        end
    end

    // Operands captured at accept, later writebacks do not touch them
    always_ff @(posedge clock) begin
        if (accept) begin
            outPc     <= insnPc;
            outInsn   <= insnWord;
            outRsData <= rsData;
            outRtData <= rtData;
            outImm    <= decImm;
            outDest   <= decDest;
            outCtrl   <= decCtrl;
        end
    end

    assign outKind    = outCtrl.kind;
    assign outRegWe   = outCtrl.regWe;
    assign outMemRead = outCtrl.memRead;
    assign outMemWe   = outCtrl.memWe;
    assign outLink    = outCtrl.link;

endmodule

/* sim/decodeStage_asserts.sv */
/*
 * Decode stage assertions
 * Handshake payload stability, reset state and the read-after-write interlock
 */
`timescale 1ns/1ps
`include "decode_config.svh"

module decodeStage_asserts (
    input logic                   clock,
    input logic                   rstN,
    input logic                   insnValid,
    input logic                   insnReady,
    input logic [`DATA_WIDTH-1:0] insnWord,
    input logic [`DATA_WIDTH-1:0] insnPc,
    input logic                   useRs,
    input logic                   useRt,
    input logic                   outValid,
    input logic                   outReady,
    input logic [`DATA_WIDTH-1:0] outPc,
    input logic [`DATA_WIDTH-1:0] outInsn,
    input logic [`DATA_WIDTH-1:0] outRsData,
    input logic [`DATA_WIDTH-1:0] outRtData,
    hazardIf.monitor              hz
);

    logic [`REG_IDX_W-1:0] rs;
    logic [`REG_IDX_W-1:0] rt;
    logic                  rsPending;
    logic                  rtPending;
    int                    errorCount = 0;  // Failed assertions so far

    assign rs = insnWord[25:21];
    assign rt = insnWord[20:16];
    assign rsPending = (rs != '0) &&
                       ((hz.aluWe && hz.aluRd == rs) || (hz.memWe && hz.memRd == rs));
    assign rtPending = (rt != '0) &&
                       ((hz.aluWe && hz.aluRd == rt) || (hz.memWe && hz.memRd == rt));

    outHeld: assert property (@(posedge clock) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable({outPc, outInsn, outRsData, outRtData}))
        else begin
            $error("output payload changed while stalled by outReady");
            errorCount++;
        end

    // Fetch side must hold its offer
    inHeld: assert property (@(posedge clock) disable iff (!rstN)
        insnValid && !insnReady |=> insnValid && $stable({insnWord, insnPc}))
        else begin
            $error("input payload changed before its transfer");
            errorCount++;
        end

    resetLow: assert property (@(posedge clock) !rstN |-> !outValid)
        else begin
            $error("outValid high during reset");
            errorCount++;
        end

    interlock: assert property (@(posedge clock) disable iff (!rstN)
        insnValid && ((useRs && rsPending) || (useRt && rtPending)) |-> !insnReady)
        else begin
            $error("instruction accepted over a pending register write");
            errorCount++;
        end

endmodule

bind decodeStage decodeStage_asserts uAsserts (
    .clock     (clock),
    .rstN      (rstN),
    .insnValid (insnValid),
    .insnReady (insnReady),
    .insnWord  (insnWord),
    .insnPc    (insnPc),
    .useRs     (useRs),
    .useRt     (useRt),
    .outValid  (outValid),
    .outReady  (outReady),
    .outPc     (outPc),
    .outInsn   (outInsn),
    .outRsData (outRsData),
    .outRtData (outRtData),
    .hz        (hz)
);

/* sim/decodeStage_tb.sv */
/*
 * Decode stage testbench
 * Random instruction stream against a register and decode model, with scoreboard
 */
`timescale 1ns/1ps
`include "decode_config.svh"

module decodeStage_tb;

    import decodePkg::*;

    localparam int SEED       = 57018;
    localparam int NUM_INSNS  = 2000;
    localparam int MAX_CYCLES = 20000;
    localparam logic [83:0] OP_LIST = {OP_SPECIAL, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE,
        OP_BLEZ, OP_BGTZ, OP_ADDIU, OP_SLTI, OP_ORI, OP_LUI, OP_LW, OP_SW};

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] insn;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;
        logic [4:0]  dest;
        insnKind_e   kind;
        logic        regWe;
        logic        memRead;
        logic        memWe;
        logic        link;
    } item_t;

    typedef struct packed {
        insnKind_e   kind;
        logic [4:0]  dest;
        logic        regWe;
        logic        memRead;
        logic        memWe;
        logic        link;
        logic        useRs;
        logic        useRt;
        logic [31:0] imm;
    } dec_t;

    logic        clock;
    logic        rstN;
    logic        insnValid;
    logic        insnReady;
    logic [31:0] insnWord;
    logic [31:0] insnPc;
    logic        wbWe;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        aluWe;
    logic [4:0]  aluRd;
    logic        memWe;
    logic [4:0]  memRd;
    logic        outReady;
    logic        outValid;
    logic [31:0] outPc;
    logic [31:0] outInsn;
    logic [31:0] outRsData;
    logic [31:0] outRtData;
    logic [31:0] outImm;
    logic [4:0]  outDest;
    insnKind_e   outKind;
    logic        outRegWe;
    logic        outMemRead;
    logic        outMemWe;
    logic        outLink;

    logic [31:0] modelRegs [32];
    item_t       scoreboard [$];

    decodeStage dut (.*);

    always #10 clock = ~clock;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            stopOnError($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                  $time, what, actual, expected));
        end
    endtask

    // Small indices most of the time so hazards and forwarding show up
    function automatic logic [4:0] randIdx();
        return ($urandom_range(0, 1) == 0) ? 5'($urandom_range(0, 3)) : 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] randInsn();
        logic [31:0] w;
        w = $urandom;
        if ($urandom_range(0, 7) == 0) return w;  // Raw word, often an unknown opcode
        w[31:26] = OP_LIST[6 * $urandom_range(0, 13) +: 6];
        w[25:21] = randIdx();
        w[20:16] = randIdx();
        w[15:11] = randIdx();
        if (w[31:26] == OP_SPECIAL && $urandom_range(0, 3) == 0) w[5:0] = FUNCT_JR;
        return w;
    endfunction

    function automatic dec_t modelDecode(input logic [31:0] w);
        dec_t       d;
        logic [5:0] op;
        logic [4:0] target;  // Register written, 0 when none
        logic       isR;
        logic       isJr;
        logic       isI;
        logic       isJ;
        op   = w[31:26];
        isR  = (op == OP_SPECIAL);
        isJr = isR && (w[5:0] == FUNCT_JR);
        isJ  = op inside {OP_J, OP_JAL};
        isI  = op inside {OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDIU, OP_SLTI,
                          OP_ORI, OP_LUI, OP_LW, OP_SW};
        d = '0;
        d.kind  = isR ? kindR : isJ ? kindJ : isI ? kindI : kindInvalid;
        d.useRs = (isR || isI) && (op != OP_LUI);
        d.useRt = (isR && !isJr) || (op inside {OP_SW, OP_BEQ, OP_BNE});
        target  = '0;
        if (isR && !isJr) target = w[15:11];
        else if (op inside {OP_ADDIU, OP_SLTI, OP_ORI, OP_LUI, OP_LW}) target = w[20:16];
        else if (op == OP_JAL) target = `LINK_REG;
        d.dest    = target;
        d.regWe   = (target != 5'd0);
        d.memRead = (op == OP_LW);
        d.memWe   = (op == OP_SW);
        d.link    = (op == OP_JAL);
        if (op == OP_ORI) d.imm = {16'h0, w[15:0]};
        else if (op == OP_LUI) d.imm = {w[15:0], 16'h0};
        else if (isJ) d.imm = {6'h0, w[25:0]};
        else if (isI) d.imm = {{16{w[15]}}, w[15:0]};
        return d;
    endfunction

    function automatic logic pendingWrite(input logic [4:0] idx);
        return (idx != 5'd0) && ((aluWe && aluRd == idx) || (memWe && memRd == idx));
    endfunction

    function automatic logic [31:0] readModel(input logic [4:0] idx);
        if (idx == 5'd0) return '0;
        return (wbWe && wbRd == idx) ? wbData : modelRegs[idx];  // Same cycle writeback
    endfunction

    function automatic item_t modelItem();
        item_t it;
        dec_t  d;
        d = modelDecode(insnWord);
        it.pc      = insnPc;
        it.insn    = insnWord;
        it.rsData  = readModel(insnWord[25:21]);
        it.rtData  = readModel(insnWord[20:16]);
        it.imm     = d.imm;
        it.dest    = d.dest;
        it.kind    = d.kind;
        it.regWe   = d.regWe;
        it.memRead = d.memRead;
        it.memWe   = d.memWe;
        it.link    = d.link;
        return it;
    endfunction

    function automatic item_t captureOut();
        return '{outPc, outInsn, outRsData, outRtData, outImm, outDest, outKind,
                 outRegWe, outMemRead, outMemWe, outLink};
    endfunction

    task automatic compareItem(input item_t got, input item_t exp, input string where);
        checkEq(got.pc, exp.pc, {where, " pc"});
        checkEq(got.insn, exp.insn, {where, " insn"});
        checkEq(got.rsData, exp.rsData, {where, " rsData"});
        checkEq(got.rtData, exp.rtData, {where, " rtData"});
        checkEq(got.imm, exp.imm, {where, " imm"});
        checkEq(got.dest, exp.dest, {where, " dest"});
        checkEq(got.kind, exp.kind, {where, " kind"});
        checkEq(got.regWe, exp.regWe, {where, " regWe"});
        checkEq(got.memRead, exp.memRead, {where, " memRead"});
        checkEq(got.memWe, exp.memWe, {where, " memWe"});
        checkEq(got.link, exp.link, {where, " link"});
    endtask

    task automatic driveCycle(input logic allowNew, input logic holdOffer);
        if (!holdOffer) begin
            insnValid = allowNew && ($urandom_range(0, 4) != 0);
            insnWord  = randInsn();
            insnPc    = insnPc + 32'd4;
        end
        wbWe     = $urandom_range(0, 1);
        wbRd     = randIdx();
        wbData   = $urandom;
        aluWe    = $urandom_range(0, 1);
        aluRd    = randIdx();
        memWe    = $urandom_range(0, 1);
        memRd    = randIdx();
        outReady = ($urandom_range(0, 3) != 0);
    endtask

    initial begin
        item_t held;
        logic  holdPrev;
        logic  holdOffer;
        logic  expValid;
        logic  expReady;
        logic  hazard;
        logic  inXfer;
        logic  outXfer;
        dec_t  d;
        int    accepted;
        int    cycles;
        void'($urandom(SEED));
        clock = 1'b0;
        rstN = 1'b0;
        insnValid = 1'b0;
        insnWord = '0;
        insnPc = 32'h0040_0000;
        wbWe = 1'b0;
        wbRd = '0;
        wbData = '0;
        aluWe = 1'b0;
        aluRd = '0;
        memWe = 1'b0;
        memRd = '0;
        outReady = 1'b0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        repeat (10) begin
            @(negedge clock);
            checkEq(outValid, 1'b0, "outValid in reset");
        end
        rstN = 1'b1;
        holdPrev = 1'b0;
        holdOffer = 1'b0;
        expValid = 1'b0;
        accepted = 0;
        cycles = 0;
        while (accepted < NUM_INSNS || scoreboard.size() != 0) begin
            if (cycles == MAX_CYCLES) begin
                stopOnError($sformatf(
                    "Timed out after %0d cycles with %0d accepted and %0d waiting",
                    cycles, accepted, scoreboard.size()));
            end
            @(negedge clock);
            cycles++;
            driveCycle(accepted < NUM_INSNS, holdOffer);
            #1;
            if (dut.uAsserts.errorCount != 0) begin
                stopOnError("A bound assertion failed on an earlier clock edge");
            end
            checkEq(outValid, expValid, "outValid one cycle after accept");
            if (holdPrev) compareItem(captureOut(), held, "held output");
            d = modelDecode(insnWord);
            hazard = (d.useRs && pendingWrite(insnWord[25:21])) ||
                     (d.useRt && pendingWrite(insnWord[20:16]));
            expReady = (!expValid || outReady) && !(insnValid && hazard);
            checkEq(insnReady, expReady, "insnReady");
            inXfer  = insnValid && insnReady;
            outXfer = outValid && outReady;
            if (outXfer) begin
                if (scoreboard.size() == 0) stopOnError("Output transfer with nothing accepted");
                compareItem(captureOut(), scoreboard.pop_front(), "output item");
            end
            if (inXfer) begin
                scoreboard.push_back(modelItem());
                accepted++;
            end
            holdOffer = insnValid && !inXfer;
            holdPrev  = outValid && !outReady;
            held      = captureOut();
            expValid  = inXfer || (expValid && !outReady);
            if (wbWe && wbRd != 5'd0) modelRegs[wbRd] = wbData;  // Lands at the next edge
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/decodePkg.sv
hw/hazardIf.sv
hw/regFile.sv
hw/insnDecoder.sv
hw/hazardUnit.sv
hw/decodeStage.sv
sim/decodeStage_asserts.sv
sim/decodeStage_tb.sv
